// ==== hw/csr_settings.svh ====
// ==========================================================
// Build settings for the machine CSR unit
// Only CSR_XLEN = 32 is supported, RV64 is not built
// Identity values are fixed when the design is compiled
// ==========================================================

`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

// ==========================================================
// Datapath width
// ==========================================================

// Register width in bits
`define CSR_XLEN 32

// ==========================================================
// Hardwired identity values
// ==========================================================

// mimpid contents, first implementation
`define CSR_MIMPID_VALUE 32'h0000_0001

// mhartid contents
`define CSR_HART_ID 32'h0000_0000   // Single hart system

// mvendorid and marchid read as zero

`endif

// ==== hw/csr_pkg.sv ====
// ==========================================================
// Types shared by the machine CSR unit
// mstatus_t assumes CSR_XLEN of at least 13 bits
// ==========================================================

`include "csr_settings.svh"

package csr_pkg;

  typedef logic [`CSR_XLEN-1:0] csr_word_t;   // One CSR data word

  // Standard machine CSR addresses
  typedef enum logic [11:0] {
    CSR_MSTATUS   = 12'h300,
    CSR_MISA      = 12'h301,
    CSR_MIE       = 12'h304,
    CSR_MTVEC     = 12'h305,
    CSR_MSCRATCH  = 12'h340,
    CSR_MEPC      = 12'h341,
    CSR_MCAUSE    = 12'h342,
    CSR_MTVAL     = 12'h343,
    CSR_MIP       = 12'h344,
    CSR_MVENDORID = 12'hF11,   // Read-only identity block
    CSR_MARCHID   = 12'hF12,
    CSR_MIMPID    = 12'hF13,
    CSR_MHARTID   = 12'hF14
  } csr_addr_e;

  // funct3 of the Zicsr instructions
  typedef enum logic [2:0] {
    CSR_OP_RW  = 3'b001,
    CSR_OP_RS  = 3'b010,
    CSR_OP_RC  = 3'b011,
    CSR_OP_RWI = 3'b101,   // Immediate forms, uimm already zero-extended
    CSR_OP_RSI = 3'b110,
    CSR_OP_RCI = 3'b111
  } csr_op_e;

  typedef enum logic [1:0] {
    PRIV_USER    = 2'b00,
    PRIV_SUPER   = 2'b01,
    PRIV_MACHINE = 2'b11
  } priv_e;

  // mstatus with only the M-mode fields kept
  typedef struct packed {
    logic [`CSR_XLEN-14:0] rsvd_hi;   // 31:13
    logic [1:0]            mpp;       // 12:11
    logic [2:0]            rsvd_10_8;
    logic                  mpie;      // 7
    logic [2:0]            rsvd_6_4;
    logic                  mie;       // 3
    logic [2:0]            rsvd_2_0;
  } mstatus_t;

  localparam csr_word_t MISA_VALUE = 32'h4000_1129;   // MXL=1, I M A F D

endpackage

// ==== hw/csr_access_if.sv ====
// ==========================================================
// One accepted CSR access, controller to register bank
// rdata is combinational from addr, write_en lasts one cycle
// ==========================================================

interface csr_access_if;
  import csr_pkg::*;

  csr_addr_e addr;       // Target CSR
  csr_op_e   op;         // Operation of the access
  csr_word_t wdata;      // Final value to store, already merged
  bit        write_en;   // Commit on the next rising edge
  csr_word_t rdata;      // Current contents of addr

  // Controller side
  modport ctrl (
    output addr, op, wdata, write_en,
    input  rdata
  );

  // Register bank side
  modport regs (
    input  addr, wdata, write_en,
    output rdata
  );

endinterface

// ==== hw/csr_access_ctrl.sv ====
// ==========================================================
// Four-phase req/ack front end of the CSR unit
// Request fields must hold stable from req until ack
// Illegal accesses return zero and write nothing
// ==========================================================

module csr_access_ctrl (
  input  logic               clk,
  input  logic               reset_n,
  input  logic               req,
  input  csr_pkg::csr_addr_e addr,
  input  csr_pkg::csr_op_e   op,
  input  csr_pkg::csr_word_t wdata,
  input  logic               write,
  input  csr_pkg::priv_e     current_priv,
  output logic               ack,
  output csr_pkg::csr_word_t rdata,
  output logic               illegal,
  csr_access_if.ctrl         acc
);
  import csr_pkg::*;

  logic      accept;        // Request seen, not yet acked
  logic      addr_exists;
  logic      priv_ok;
  logic      read_only;
  logic      access_bad;    // Any legality rule broken
  csr_word_t new_value;     // Read-modify-write result

  // ==========================================================
  // Legality check
  // ==========================================================

  always_comb begin
    case (addr)
      CSR_MSTATUS, CSR_MISA, CSR_MIE, CSR_MTVEC,
      CSR_MSCRATCH, CSR_MEPC, CSR_MCAUSE, CSR_MTVAL, CSR_MIP,
      CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID, CSR_MHARTID: addr_exists = 1'b1;
      default:                                              addr_exists = 1'b0;
    endcase
  end

  assign priv_ok    = (current_priv >= addr[9:8]);   // Level encoded in address
  assign read_only  = (addr[11:10] == 2'b11) || (addr == CSR_MISA);
  assign access_bad = !addr_exists || !priv_ok || (write && read_only);

  // ==========================================================
  // New value and bank write
  // ==========================================================

  assign accept = req && !ack;

  always_comb begin
    case (acc.op)
      CSR_OP_RW, CSR_OP_RWI: new_value = wdata;
      CSR_OP_RS, CSR_OP_RSI: new_value = acc.rdata | wdata;
      CSR_OP_RC, CSR_OP_RCI: new_value = acc.rdata & ~wdata;
      default:               new_value = acc.rdata;   // Reserved funct3, keep old
    endcase
  end

  assign acc.addr     = addr;
  assign acc.op       = op;
  assign acc.wdata    = new_value;
  assign acc.write_en = accept && write && !access_bad;   // High only in the accept cycle

  // ==========================================================
  // Handshake state
  // ==========================================================

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      ack     <= 1'b0;
      illegal <= 1'b0;
    end else if (accept) begin
      ack     <= 1'b1;
      illegal <= access_bad;
    end else if (ack && !req) begin
      ack     <= 1'b0;   // Requester released, ready for next
    end
  end

  // Pre-write value, zero when rejected
  always_ff @(posedge clk) begin
    if (accept) begin
      rdata <= access_bad ? '0 : acc.rdata;
    end
  end

  // ack only follows a request
  a_ack_needs_req : assert property (@(posedge clk) disable iff (!reset_n)
    $rose(ack) |-> $past(req));

  // A committed write never reports illegal
  a_write_is_legal : assert property (@(posedge clk) disable iff (!reset_n)
    acc.write_en |=> !illegal);

endmodule

// ==== hw/csr_machine_regs.sv ====
// ==========================================================
// Machine CSR bank with trap entry and MRET
// Traps always enter machine mode, no delegation
// Priority is trap entry, then MRET, then CSR write
// ==========================================================

`include "csr_settings.svh"

module csr_machine_regs (
  input  logic               clk,
  input  logic               reset_n,
  input  csr_pkg::priv_e     current_priv,
  input  logic               trap_entry,
  input  csr_pkg::csr_word_t trap_pc,
  input  logic [4:0]         trap_cause,
  input  csr_pkg::csr_word_t trap_val,
  input  logic               mret,
  output csr_pkg::csr_word_t trap_vector,
  output csr_pkg::csr_word_t mepc_out,
  output logic               mstatus_mie,
  output logic [1:0]         mpp,
  csr_access_if.regs         acc
);
  import csr_pkg::*;

  // ==========================================================
  // Storage
  // ==========================================================

  mstatus_t  mstatus_q;
  csr_word_t mie_q;        // Interrupt enables, no interrupt logic here
  csr_word_t mtvec_q;      // Direct mode only
  csr_word_t mscratch_q;
  csr_word_t mepc_q;
  csr_word_t mcause_q;
  csr_word_t mtval_q;
  csr_word_t mip_q;        // Software writable pending bits
  mstatus_t  wr_status;    // Incoming write seen as mstatus

  assign wr_status = mstatus_t'(acc.wdata);

  // ==========================================================
  // Read multiplexer
  // ==========================================================

  always_comb begin
    case (acc.addr)
      CSR_MSTATUS:   acc.rdata = csr_word_t'(mstatus_q);
      CSR_MISA:      acc.rdata = MISA_VALUE;
      CSR_MIE:       acc.rdata = mie_q;
      CSR_MTVEC:     acc.rdata = mtvec_q;
      CSR_MSCRATCH:  acc.rdata = mscratch_q;
      CSR_MEPC:      acc.rdata = mepc_q;
      CSR_MCAUSE:    acc.rdata = mcause_q;
      CSR_MTVAL:     acc.rdata = mtval_q;
      CSR_MIP:       acc.rdata = mip_q;
      CSR_MVENDORID: acc.rdata = '0;                  // Non-commercial
      CSR_MARCHID:   acc.rdata = '0;
      CSR_MIMPID:    acc.rdata = `CSR_MIMPID_VALUE;
      CSR_MHARTID:   acc.rdata = `CSR_HART_ID;
      default:       acc.rdata = '0;                  // Unknown reads zero
    endcase
  end

  // ==========================================================
  // Update in priority order
  // ==========================================================

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      mstatus_q  <= '{mpp: PRIV_MACHINE, default: '0};   // Start with MPP = M
      mie_q      <= '0;
      mtvec_q    <= '0;
      mscratch_q <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
      mtval_q    <= '0;
      mip_q      <= '0;
    end else if (trap_entry) begin
      mepc_q         <= trap_pc;
      mcause_q       <= {{(`CSR_XLEN-5){1'b0}}, trap_cause};   // Exceptions only
      mtval_q        <= trap_val;
      mstatus_q.mpie <= mstatus_q.mie;   // Stack interrupt enable
      mstatus_q.mie  <= 1'b0;
      mstatus_q.mpp  <= current_priv;    // Remember where the trap came from
    end else if (mret) begin
      mstatus_q.mie  <= mstatus_q.mpie;
      mstatus_q.mpie <= 1'b1;
      mstatus_q.mpp  <= PRIV_USER;       // Least privileged mode
    end else if (acc.write_en) begin
      case (acc.addr)
        CSR_MSTATUS: begin
          // Reserved fields stay zero
          mstatus_q.mie  <= wr_status.mie;
          mstatus_q.mpie <= wr_status.mpie;
          mstatus_q.mpp  <= wr_status.mpp;
        end
        CSR_MIE:      mie_q      <= acc.wdata;
        CSR_MTVEC:    mtvec_q    <= {acc.wdata[`CSR_XLEN-1:2], 2'b00};   // Word aligned
        CSR_MSCRATCH: mscratch_q <= acc.wdata;
        CSR_MEPC:     mepc_q     <= {acc.wdata[`CSR_XLEN-1:1], 1'b0};    // Halfword aligned
        CSR_MCAUSE:   mcause_q   <= acc.wdata;
        CSR_MTVAL:    mtval_q    <= acc.wdata;
        CSR_MIP:      mip_q      <= acc.wdata;
        default: begin
          // Read-only or absent, nothing stored
        end
      endcase
    end
  end

  // ==========================================================
  // Outputs to the core
  // ==========================================================

  assign trap_vector = mtvec_q;   // No delegation, always mtvec
  assign mepc_out    = mepc_q;
  assign mstatus_mie = mstatus_q.mie;
  assign mpp         = mstatus_q.mpp;

  // Pipeline never retires a trap and MRET together
  a_trap_mret_excl : assert property (@(posedge clk) disable iff (!reset_n)
    !(trap_entry && mret));

endmodule

// ==== hw/csr_unit.sv ====
// ==========================================================
// Machine-mode CSR unit, top level
// Accesses use four-phase req/ack, one at a time
// trap_entry and mret are single-cycle pulses
// ==========================================================

module csr_unit (
  input  logic               clk,
  input  logic               reset_n,
  // CSR access handshake
  input  logic               req,
  input  logic [11:0]        addr,
  input  logic [2:0]         op,
  input  csr_pkg::csr_word_t wdata,
  input  logic               write,
  output logic               ack,
  output csr_pkg::csr_word_t rdata,
  output logic               illegal,
  input  logic [1:0]         current_priv,
  // Trap and return
  input  logic               trap_entry,
  input  csr_pkg::csr_word_t trap_pc,
  input  logic [4:0]         trap_cause,
  input  csr_pkg::csr_word_t trap_val,
  input  logic               mret,
  output csr_pkg::csr_word_t trap_vector,
  output csr_pkg::csr_word_t mepc_out,
  output logic               mstatus_mie,
  output logic [1:0]         mpp
);
  import csr_pkg::*;

  csr_access_if acc ();   // Controller to bank

  csr_access_ctrl u_access_ctrl (
    .clk          (clk),
    .reset_n      (reset_n),
    .req          (req),
    .addr         (csr_addr_e'(addr)),
    .op           (csr_op_e'(op)),
    .wdata        (wdata),
    .write        (write),
    .current_priv (priv_e'(current_priv)),
    .ack          (ack),
    .rdata        (rdata),
    .illegal      (illegal),
    .acc          (acc.ctrl)
  );

  csr_machine_regs u_machine_regs (
    .clk          (clk),
    .reset_n      (reset_n),
    .current_priv (priv_e'(current_priv)),
    .trap_entry   (trap_entry),
    .trap_pc      (trap_pc),
    .trap_cause   (trap_cause),
    .trap_val     (trap_val),
    .mret         (mret),
    .trap_vector  (trap_vector),
    .mepc_out     (mepc_out),
    .mstatus_mie  (mstatus_mie),
    .mpp          (mpp),
    .acc          (acc.regs)
  );

endmodule

// ==== verif/csr_unit_tb.sv ====
// ==========================================================
// Self-checking testbench for the machine CSR unit
// Vectors and expected values come from verif/csr_unit_input.txt
// Inputs change on the falling edge, outputs sampled there too
// ==========================================================

module csr_unit_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import csr_pkg::*;

  localparam int MAX_VECTORS = 64;

  logic        clk;
  logic        reset_n;
  logic        req;
  logic [11:0] addr;
  logic [2:0]  op;
  csr_word_t   wdata;
  logic        write;
  logic [1:0]  current_priv;
  logic        trap_entry;
  csr_word_t   trap_pc;
  logic [4:0]  trap_cause;
  csr_word_t   trap_val;
  logic        mret;
  logic        ack;
  csr_word_t   rdata;
  logic        illegal;
  csr_word_t   trap_vector;
  csr_word_t   mepc_out;
  logic        mstatus_mie;
  logic [1:0]  mpp;

  // ==========================================================
  // Vector storage and run bookkeeping
  // ==========================================================

  byte         vec_kind  [0:MAX_VECTORS-1];        // A, T, M or O
  logic [31:0] vec_field [0:MAX_VECTORS-1][0:6];   // Fields in file order
  int          vec_count;
  int          mismatch_count;
  int          other_count;                        // Non-value failures
  int          cycle_count;
  int          cycle_limit;
  integer      seed;

  csr_unit u_csr_unit (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;   // 20 ns period
  end

  // Compare and log one value
  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
      mismatch_count++;
    end
  endtask

  // Parse the vector file, comment lines start with #
  task automatic load_vectors();
    integer            fd;
    integer            code;
    string             token;
    logic [8*256-1:0]  rest;
    logic [31:0]       v [0:6];
    bit                done;
    fd   = $fopen("verif/csr_unit_input.txt", "r");
    done = 1'b0;
    if (fd == 0) begin
      $display("Could not open the vector file verif/csr_unit_input.txt");
      other_count++;
      done = 1'b1;
    end
    while (!done) begin
      code = $fscanf(fd, "%s", token);
      if (code != 1) begin
        done = 1'b1;                          // End of file
      end else if (token[0] == "#") begin
        code = $fgets(rest, fd);
      end else if (vec_count >= MAX_VECTORS) begin
        $display("Vector file holds more than %0d vectors", MAX_VECTORS);
        other_count++;
        done = 1'b1;
      end else begin
        for (int k = 0; k < 7; k++) v[k] = '0;
        case (token[0])
          "A": code = $fscanf(fd, "%h %h %h %h %h %h %h",
                              v[0], v[1], v[2], v[3], v[4], v[5], v[6]);
          "T": code = $fscanf(fd, "%h %h %h %h", v[0], v[1], v[2], v[3]);
          "O": code = $fscanf(fd, "%h %h %h %h", v[0], v[1], v[2], v[3]);
          "M": code = 0;
          default: begin
            $display("Unknown vector kind %s in the vector file", token);
            other_count++;
            code = $fgets(rest, fd);
          end
        endcase
        vec_kind[vec_count] = token[0];
        for (int k = 0; k < 7; k++) vec_field[vec_count][k] = v[k];
        vec_count++;
      end
    end
    if (fd != 0) $fclose(fd);
  endtask

  // ==========================================================
  // Operations
  // ==========================================================

  // One four-phase CSR access
  task automatic do_access(input int idx);
    @(negedge clk);
    req          = 1'b1;
    op           = vec_field[idx][0][2:0];
    addr         = vec_field[idx][1][11:0];
    wdata        = vec_field[idx][2];
    write        = vec_field[idx][3][0];
    current_priv = vec_field[idx][4][1:0];
    do begin
      @(negedge clk);
    end while (!ack);
    check_value(rdata, vec_field[idx][5], $sformatf("vector %0d rdata", idx));
    check_value({31'b0, illegal}, vec_field[idx][6], $sformatf("vector %0d illegal", idx));
    req = 1'b0;
    do begin
      @(negedge clk);
    end while (ack);                          // Wait for the release phase
  endtask

  // Single-cycle trap entry pulse
  task automatic pulse_trap(input int idx);
    @(negedge clk);
    trap_entry   = 1'b1;
    trap_pc      = vec_field[idx][0];
    trap_cause   = vec_field[idx][1][4:0];
    trap_val     = vec_field[idx][2];
    current_priv = vec_field[idx][3][1:0];
    @(negedge clk);
    trap_entry   = 1'b0;
  endtask

  task automatic pulse_mret();
    @(negedge clk);
    mret = 1'b1;
    @(negedge clk);
    mret = 1'b0;
  endtask

  task automatic check_outputs(input int idx);
    @(negedge clk);
    check_value(trap_vector, vec_field[idx][0], $sformatf("vector %0d trap_vector", idx));
    check_value(mepc_out, vec_field[idx][1], $sformatf("vector %0d mepc_out", idx));
    check_value({31'b0, mstatus_mie}, vec_field[idx][2],
                $sformatf("vector %0d mstatus_mie", idx));
    check_value({30'b0, mpp}, vec_field[idx][3], $sformatf("vector %0d mpp", idx));
  endtask

  task automatic run_vector(input int idx);
    int unsigned gap;
    gap = $unsigned($random(seed)) % 4;       // Idle 0 to 3 cycles
    repeat (gap) @(negedge clk);
    case (vec_kind[idx])
      "A":     do_access(idx);
      "T":     pulse_trap(idx);
      "M":     pulse_mret();
      "O":     check_outputs(idx);
      default: ;                              // Already reported while loading
    endcase
  endtask

  // ==========================================================
  // Main sequence and watchdog
  // ==========================================================

  initial begin
    reset_n        = 1'b0;
    req            = 1'b0;
    addr           = '0;
    op             = '0;
    wdata          = '0;
    write          = 1'b0;
    current_priv   = 2'b11;
    trap_entry     = 1'b0;
    trap_pc        = '0;
    trap_cause     = '0;
    trap_val       = '0;
    mret           = 1'b0;
    seed           = 32'ha4aa77fe;
    vec_count      = 0;
    mismatch_count = 0;
    other_count    = 0;
    load_vectors();
    cycle_limit = 16 + 10 * vec_count + 50;
    repeat (16) @(negedge clk);
    reset_n = 1'b1;
    for (int i = 0; i < vec_count; i++) run_vector(i);
    $display("Error counts: %0d mismatches, %0d other errors over %0d vectors",
             mismatch_count, other_count, vec_count);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  initial begin
    cycle_count = 0;
    wait (cycle_limit != 0);
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
    $display("tests failed");
    $finish;
  end

endmodule

// ==== verif/csr_unit_input.txt ====
# A op addr wdata write priv exp_rdata exp_illegal | T pc cause val priv | M
# O exp_trap_vector exp_mepc_out exp_mstatus_mie exp_mpp (all fields hex)
A 1 340 12345678 1 3 00000000 0
A 2 340 0000F000 1 3 12345678 0
A 3 340 00000078 1 3 1234F678 0
A 2 340 00000000 0 3 1234F600 0
A 2 7C0 00000000 0 3 00000000 1
A 1 301 FFFFFFFF 1 3 00000000 1
A 2 301 00000000 0 3 40001129 0
A 1 F14 00000001 1 3 00000000 1
A 2 F14 00000000 0 3 00000000 0
A 2 F13 00000000 0 3 00000001 0
A 1 340 DEADBEEF 1 0 00000000 1
A 2 340 00000000 0 3 1234F600 0
A 1 305 FFFFFFFF 1 3 00000000 0
A 2 305 00000000 0 3 FFFFFFFC 0
A 1 341 FFFFFFFF 1 3 00000000 0
A 2 341 00000000 0 3 FFFFFFFE 0
O FFFFFFFC FFFFFFFE 0 3
A 6 300 00000008 1 3 00001800 0
T 80000100 2 00000013 0
O FFFFFFFC 80000100 0 0
A 2 341 00000000 0 3 80000100 0
A 2 342 00000000 0 3 00000002 0
A 2 343 00000000 0 3 00000013 0
A 2 300 00000000 0 3 00000080 0
M
A 2 300 00000000 0 3 00000088 0
O FFFFFFFC 80000100 1 0

// ==== csr_unit.f ====
+incdir+hw
hw/csr_pkg.sv
hw/csr_access_if.sv
hw/csr_access_ctrl.sv
hw/csr_machine_regs.sv
hw/csr_unit.sv
verif/csr_unit_tb.sv

// ==== Bender.yml ====
package:
  name: csr_unit

sources:
  - include_dirs:
      - hw
    files:
      - hw/csr_pkg.sv
      - hw/csr_access_if.sv
      - hw/csr_access_ctrl.sv
      - hw/csr_machine_regs.sv
      - hw/csr_unit.sv
  - target: test
    files:
      - verif/csr_unit_tb.sv
